// ==== flist.f ====
source/quad_ctrl_pkg.sv
source/quad_ctrl_ifs.sv
source/pfb_fetch_tracker.sv
source/raster_tracker.sv
source/ce_start_chain.sv
source/quad_ctrl_fsm.sv
source/cnn_quad_bram_ctrl.sv
verification/quad_ctrl_assertions.sv
verification/tb_cnn_quad_bram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_cnn_quad_bram_ctrl -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== source/ce_start_chain.sv ====
module ce_start_chain
    import quad_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      seq_rden,
    input  logic      active,
    output ce_start_t ce_start
);

    // Sequencer read to data valid latency
    logic [SEQ_RDEN_DELAY-1:0] seq_rden_dly;
    // First engine start while executing
    logic                      start_bit;

    assign start_bit = active && seq_rden_dly[SEQ_RDEN_DELAY-1];

    //////////////////////////////////////////////////
    // Delay line and staggered start chain
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rden_dly <= '0;
            ce_start     <= '0;
        end else begin
            seq_rden_dly <= {seq_rden_dly[SEQ_RDEN_DELAY-2:0], seq_rden};
            // Each engine starts one cycle after its neighbour
            ce_start <= {ce_start[CE_START_W-2:0], start_bit};
        end
    end

endmodule

// ==== source/cnn_quad_bram_ctrl.sv ====
module cnn_quad_bram_ctrl
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  coord_t     num_input_cols,
    input  coord_t     num_input_rows,
    input  logic       job_start,
    input  logic       job_fetch_ack,
    input  logic       job_fetch_complete,
    input  logic       job_complete_ack,
    input  pfb_count_t pfb_full_count,
    input  logic       row_matric,
    input  logic       last_kernel,
    input  logic       next_row,
    output logic       job_accept,
    output logic       job_fetch_request,
    output logic       job_complete,
    output coord_t     input_row,
    output coord_t     input_col,
    output logic [1:0] gray_code,
    output logic       pfb_rden,
    output coord_t     wr_addr,
    output ce_start_t  ce_start,
    output logic       seq_rden
);

    pfb_status_if pfb_bus ();
    raster_if     pos_bus ();

    // ACTIVE state flag for the start chain
    logic active;

    assign input_row = pos_bus.input_row;
    assign input_col = pos_bus.input_col;
    assign pfb_rden  = pfb_bus.pfb_rden;

    //////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////

    pfb_fetch_tracker u_fetch (
        .clk                (clk),
        .rst                (rst),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .pfb_full_count     (pfb_full_count),
        .pfb                (pfb_bus)
    );

    raster_tracker u_raster (
        .clk            (clk),
        .rst            (rst),
        .num_input_cols (num_input_cols),
        .next_row       (next_row),
        .gray_code      (gray_code),
        .pfb            (pfb_bus),
        .pos            (pos_bus)
    );

    ce_start_chain u_ce_chain (
        .clk      (clk),
        .rst      (rst),
        .seq_rden (seq_rden),
        .active   (active),
        .ce_start (ce_start)
    );

    quad_ctrl_fsm u_fsm (
        .clk                (clk),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .num_input_cols     (num_input_cols),
        .num_input_rows     (num_input_rows),
        .pfb_full_count     (pfb_full_count),
        .row_matric         (row_matric),
        .last_kernel        (last_kernel),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .seq_rden           (seq_rden),
        .active             (active),
        .wr_addr            (wr_addr),
        .pfb                (pfb_bus),
        .pos                (pos_bus)
    );

endmodule

// ==== source/pfb_fetch_tracker.sv ====
module pfb_fetch_tracker
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_fetch_ack,
    input  logic       job_fetch_complete,
    input  pfb_count_t pfb_full_count,
    pfb_status_if.tracker pfb
);

    fetch_state_t fetch_state;

    // Completion only counts once the request was acknowledged
    assign pfb.fetch_loaded = job_fetch_complete && (fetch_state == ROW_REQUEST);

    //////////////////////////////////////////////////
    // Fetch handshake state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_state <= FETCH_IDLE;
        end else begin
            unique case (fetch_state)
                FETCH_IDLE: begin
                    // Responder took the request, row is on its way
                    if (job_fetch_ack) begin
                        fetch_state <= ROW_REQUEST;
                    end
                end
                ROW_REQUEST: begin
                    if (job_fetch_complete) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
                default: fetch_state <= FETCH_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // PFB fill level
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb.pfb_count      <= '0;
            pfb.pfb_count_prev <= '0;
        end else begin
            // A pop wins over a refill in the same cycle
            if (pfb.pfb_rden) begin
                pfb.pfb_count <= pfb.pfb_count - 1'b1;
            end else if (pfb.fetch_loaded) begin
                pfb.pfb_count <= pfb_full_count;
            end
            // Previous level, used to see a drained buffer settle
            pfb.pfb_count_prev <= pfb.pfb_count;
        end
    end

endmodule

// ==== source/quad_ctrl_fsm.sv ====
module quad_ctrl_fsm
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_start,
    input  logic       job_fetch_ack,
    input  logic       job_fetch_complete,
    input  logic       job_complete_ack,
    input  coord_t     num_input_cols,
    input  coord_t     num_input_rows,
    input  pfb_count_t pfb_full_count,
    input  logic       row_matric,
    input  logic       last_kernel,
    output logic       job_accept,
    output logic       job_fetch_request,
    output logic       job_complete,
    output logic       seq_rden,
    output logic       active,
    output coord_t     wr_addr,
    pfb_status_if.fsm  pfb,
    raster_if.sink     pos
);

    ctrl_state_t             state;
    // State to resume after a PFB refill
    ctrl_state_t             prev_state;
    logic [ACCEPT_CNT_W-1:0] accept_cnt;
    // Request was taken, wait for the row to land
    logic                    fetch_acked;
    logic                    pfb_rden_q;

    assign pfb.pfb_rden = pfb_rden_q;
    assign active       = (state == ACTIVE);

    //////////////////////////////////////////////////
    // Job state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            prev_state        <= IDLE;
            accept_cnt        <= '0;
            job_accept        <= 1'b0;
            fetch_acked       <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pfb_rden_q        <= 1'b0;
            seq_rden          <= 1'b0;
            wr_addr           <= '0;
        end else begin
            // Strobes drop unless a state holds them
            pfb_rden_q        <= 1'b0;
            seq_rden          <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;

            // Accept pulse countdown
            if (accept_cnt != '0) begin
                accept_cnt <= accept_cnt - 1'b1;
            end else begin
                job_accept <= 1'b0;
            end

            unique case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        accept_cnt <= ACCEPT_CNT_W'(ACCEPT_STRETCH - 1);
                        state      <= PRIME_BUFFER;
                    end
                end
                PRIME_BUFFER: begin
                    // PFB drained and settled, more rows still needed
                    if (pfb.pfb_count == '0 && pfb.pfb_count_prev == '0 &&
                        pos.input_row < coord_t'(PRIME_ROWS)) begin
                        prev_state <= PRIME_BUFFER;
                        state      <= WAIT_PFB_LOAD;
                    end
                    // Last primed row in and a fresh row waiting
                    if (pos.input_row == coord_t'(PRIME_ROWS - 1) &&
                        pfb.pfb_count == pfb_full_count) begin
                        state <= ACTIVE;
                    end else if (pfb.pfb_count > pfb_count_t'(1)) begin
                        // Reads are one cycle behind the count
                        pfb_rden_q <= 1'b1;
                    end
                end
                WAIT_PFB_LOAD: begin
                    // Hold the request until the responder takes it
                    if (job_fetch_ack) begin
                        fetch_acked <= 1'b1;
                    end else if (!fetch_acked) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (job_fetch_complete) begin
                        fetch_acked <= 1'b0;
                    end
                    // Row landed in the PFB
                    if (pfb.fetch_loaded) begin
                        state <= prev_state;
                    end
                end
                ACTIVE: begin
                    seq_rden <= 1'b1;
                    // Fetch next input word while the row matrix runs
                    if (row_matric && last_kernel) begin
                        wr_addr    <= wr_addr + 1'b1;
                        pfb_rden_q <= 1'b1;
                    end
                    // End of an output row
                    if (pos.output_col == num_input_cols) begin
                        seq_rden <= 1'b0;
                        if (pos.output_row == num_input_rows) begin
                            state <= JOB_DONE;
                        end else if (pfb.pfb_count != pfb_count_t'(num_input_cols)) begin
                            prev_state <= ACTIVE;
                            state      <= WAIT_PFB_LOAD;
                        end
                    end
                end
                JOB_DONE: begin
                    // Completion held until acknowledged
                    if (job_complete_ack) begin
                        state <= IDLE;
                    end else begin
                        job_complete <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== source/quad_ctrl_ifs.sv ====
//////////////////////////////////////////////////
// PFB fill status and read strobe
//////////////////////////////////////////////////

interface pfb_status_if
    import quad_ctrl_pkg::*;
();
    pfb_count_t pfb_count;
    pfb_count_t pfb_count_prev;
    // Fetch completion seen during a row request
    logic fetch_loaded;
    // One word popped from the PFB
    logic pfb_rden;

    modport tracker (
        output pfb_count,
        output pfb_count_prev,
        output fetch_loaded,
        input  pfb_rden
    );

    modport fsm (
        input  pfb_count,
        input  pfb_count_prev,
        input  fetch_loaded,
        output pfb_rden
    );
endinterface

//////////////////////////////////////////////////
// Input and output raster positions
//////////////////////////////////////////////////

interface raster_if
    import quad_ctrl_pkg::*;
();
    coord_t input_row;
    coord_t input_col;
    coord_t output_row;
    coord_t output_col;

    modport source (output input_row, output input_col, output output_row, output output_col);
    modport sink (input input_row, input input_col, input output_row, input output_col);
endinterface

// ==== source/quad_ctrl_pkg.sv ====
package quad_ctrl_pkg;

    //////////////////////////////////////////////////
    // Line buffer geometry
    //////////////////////////////////////////////////

    // Words in one line buffer
    localparam int BRAM_DEPTH = 1024;
    // Row and column index, half the buffer depth
    localparam int COORD_W = $clog2(BRAM_DEPTH) - 1;
    // PFB fill level
    localparam int PFB_COUNT_W = 9;

    // Engine array shape
    localparam int NUM_AWE = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int CE_START_W = NUM_AWE * NUM_CE_PER_AWE;

    // Job sequencing
    localparam int PRIME_ROWS = 4;
    localparam int SEQ_RDEN_DELAY = 2;
    localparam int ACCEPT_STRETCH = 5;
    // Enough bits to count down the accept pulse
    localparam int ACCEPT_CNT_W = $clog2(ACCEPT_STRETCH);

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [PFB_COUNT_W-1:0] pfb_count_t;
    typedef logic [CE_START_W-1:0] ce_start_t;

    // Main job states
    typedef enum logic [2:0] {
        IDLE,
        PRIME_BUFFER,
        WAIT_PFB_LOAD,
        ACTIVE,
        JOB_DONE
    } ctrl_state_t;

    // Row fetch states
    typedef enum logic {
        FETCH_IDLE,
        ROW_REQUEST
    } fetch_state_t;

endpackage

// ==== source/raster_tracker.sv ====
module raster_tracker
    import quad_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  coord_t     num_input_cols,
    input  logic       next_row,
    output logic [1:0] gray_code,
    pfb_status_if.fsm  pfb,
    raster_if.source   pos
);

    // Binary row pointer over the four line buffers
    logic [1:0] row_ptr;

    //////////////////////////////////////////////////
    // Input raster, advanced by PFB reads
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pos.input_row <= '0;
            pos.input_col <= '0;
        end else if (pos.input_col == num_input_cols) begin
            // End of row takes priority over a read
            pos.input_col <= '0;
            pos.input_row <= pos.input_row + 1'b1;
        end else if (pfb.pfb_rden) begin
            pos.input_col <= pos.input_col + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Output raster, advanced by consumed rows
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pos.output_row <= '0;
            pos.output_col <= '0;
        end else if (pos.output_col == num_input_cols) begin
            pos.output_col <= '0;
            pos.output_row <= pos.output_row + 1'b1;
        end else if (next_row) begin
            pos.output_col <= pos.output_col + 1'b1;
        end
    end

    // Row pointer, wraps after four rows
    always_ff @(posedge clk) begin
        if (rst) begin
            row_ptr <= '0;
        end else if (next_row) begin
            row_ptr <= row_ptr + 1'b1;
        end
    end

    // Gray encoding, one bit flips per step
    assign gray_code = {row_ptr[1], row_ptr[1] ^ row_ptr[0]};

endmodule

// ==== verification/quad_ctrl_assertions.sv ====
module quad_ctrl_assertions
    import quad_ctrl_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      job_start,
    input logic      job_accept,
    input logic      job_fetch_request,
    input logic      job_fetch_ack,
    input logic      job_complete,
    input logic      job_complete_ack,
    input logic      pfb_rden,
    input coord_t    input_col,
    input coord_t    input_row,
    input coord_t    num_input_cols,
    input logic      seq_rden,
    input ce_start_t ce_start,
    input logic      next_row,
    input logic [1:0] gray_code,
    input logic      row_matric,
    input logic      last_kernel,
    input coord_t    wr_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Running count of failed assertions
    int fail_count = 0;

    //////////////////////////////////////////////////
    // Job accept stretch
    //////////////////////////////////////////////////

    accept_follows_start: assert property (@(posedge clk) disable iff (rst)
        $rose(job_start) |=> job_accept)
        else begin
            fail_count++;
            $error("job_accept did not rise after job_start");
        end

    // Pulse high for the five cycles before the fall
    accept_five_cycles: assert property (@(posedge clk) disable iff (rst)
        $fell(job_accept) |-> $past(job_accept, 2) && $past(job_accept, 3) &&
            $past(job_accept, 4) && $past(job_accept, 5) && !$past(job_accept, 6))
        else begin
            fail_count++;
            $error("job_accept pulse is not 5 cycles long");
        end

    //////////////////////////////////////////////////
    // Fetch and completion handshakes
    //////////////////////////////////////////////////

    fetch_req_held: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
        else begin
            fail_count++;
            $error("job_fetch_request dropped before job_fetch_ack");
        end

    fetch_req_drops: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else begin
            fail_count++;
            $error("job_fetch_request still high after job_fetch_ack");
        end

    fetch_vs_complete: assert property (@(posedge clk) disable iff (rst)
        !(job_fetch_request && job_complete))
        else begin
            fail_count++;
            $error("job_fetch_request and job_complete high together");
        end

    complete_held: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            fail_count++;
            $error("job_complete dropped before job_complete_ack");
        end

    complete_drops: assert property (@(posedge clk) disable iff (rst)
        job_complete && job_complete_ack |=> !job_complete)
        else begin
            fail_count++;
            $error("job_complete still high after job_complete_ack");
        end

    //////////////////////////////////////////////////
    // Input raster, engine starts, row pointer
    //////////////////////////////////////////////////

    // Column step or wrap into the next row at the last column
    rden_moves_col: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |=> ($past(input_col) == $past(num_input_cols))
            ? (input_col == '0 && input_row == coord_t'($past(input_row) + 1'b1))
            : (input_col == coord_t'($past(input_col) + 1'b1) &&
               input_row == $past(input_row)))
        else begin
            fail_count++;
            $error("input_col or input_row wrong after pfb_rden");
        end

    ce_first_from_seq: assert property (@(posedge clk) disable iff (rst)
        ce_start[0] |-> $past(seq_rden, 3))
        else begin
            fail_count++;
            $error("ce_start[0] without seq_rden three cycles earlier");
        end

    // Stagger of one cycle per engine
    ce_chain_shift: assert property (@(posedge clk) disable iff (rst)
        ce_start[CE_START_W-1:1] == $past(ce_start[CE_START_W-2:0]))
        else begin
            fail_count++;
            $error("ce_start chain did not shift by one cycle");
        end

    gray_one_bit: assert property (@(posedge clk) disable iff (rst)
        next_row |=> $countones(gray_code ^ $past(gray_code)) == 1)
        else begin
            fail_count++;
            $error("gray_code did not change in exactly one bit");
        end

    gray_holds: assert property (@(posedge clk) disable iff (rst)
        !next_row |=> $stable(gray_code))
        else begin
            fail_count++;
            $error("gray_code changed without next_row");
        end

    //////////////////////////////////////////////////
    // Write address
    //////////////////////////////////////////////////

    // Row matrix at the last kernel while executing
    wr_addr_advances: assert property (@(posedge clk) disable iff (rst)
        seq_rden && row_matric && last_kernel |=>
            wr_addr == coord_t'($past(wr_addr) + 1'b1) && pfb_rden)
        else begin
            fail_count++;
            $error("wr_addr did not step after row_matric with last_kernel");
        end

    // Only single steps, each with its PFB read
    wr_addr_step_only: assert property (@(posedge clk) disable iff (rst)
        $changed(wr_addr) |-> wr_addr == coord_t'($past(wr_addr) + 1'b1) &&
            $past(row_matric && last_kernel) && pfb_rden)
        else begin
            fail_count++;
            $error("wr_addr changed without row_matric and last_kernel");
        end

endmodule

bind cnn_quad_bram_ctrl quad_ctrl_assertions u_assert (
    .clk               (clk),
    .rst               (rst),
    .job_start         (job_start),
    .job_accept        (job_accept),
    .job_fetch_request (job_fetch_request),
    .job_fetch_ack     (job_fetch_ack),
    .job_complete      (job_complete),
    .job_complete_ack  (job_complete_ack),
    .pfb_rden          (pfb_rden),
    .input_col         (input_col),
    .input_row         (input_row),
    .num_input_cols    (num_input_cols),
    .seq_rden          (seq_rden),
    .ce_start          (ce_start),
    .next_row          (next_row),
    .gray_code         (gray_code),
    .row_matric        (row_matric),
    .last_kernel       (last_kernel),
    .wr_addr           (wr_addr)
);

// ==== verification/tb_cnn_quad_bram_ctrl.sv ====
module tb_cnn_quad_bram_ctrl
    import quad_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int JOBS = 2;
    localparam int COLS = 3;
    localparam int ROWS = 5;
    localparam int FULL_COUNT = 4;
    localparam int MAX_DELAY = 4;
    localparam int WATCHDOG_CYCLES = JOBS * (ROWS + 1) * (COLS + 1) * MAX_DELAY * 4;
    // Lets the start chain empty before the next reset
    localparam int DRAIN_CYCLES = 12;

    logic       clk;
    logic       rst;
    coord_t     num_input_cols;
    coord_t     num_input_rows;
    logic       job_start;
    logic       job_fetch_ack;
    logic       job_fetch_complete;
    logic       job_complete_ack;
    pfb_count_t pfb_full_count;
    logic       row_matric;
    logic       last_kernel;
    logic       next_row;
    logic       job_accept;
    logic       job_fetch_request;
    logic       job_complete;
    coord_t     input_row;
    coord_t     input_col;
    logic [1:0] gray_code;
    logic       pfb_rden;
    coord_t     wr_addr;
    ce_start_t  ce_start;
    logic       seq_rden;

    int unsigned lcg_state;
    int          next_row_pulses;
    int          complete_pulses;
    int          tests_run;
    int          tests_failed;

    cnn_quad_bram_ctrl uut (.*);

    always #2 clk = ~clk;

    function automatic int next_random(input int range);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % range);
    endfunction

    // Row pointer sequence 00 01 11 10 after a number of steps
    function automatic logic [1:0] gray_for_count(input int count);
        case (count % 4)
            0:       return 2'b00;
            1:       return 2'b01;
            2:       return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) wait_cycle();
        rst = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // One job from reset to acknowledged completion
    //////////////////////////////////////////////////

    task automatic run_job(input int idx);
        int         delay;
        int         fails_before;
        logic [1:0] expected_gray;
        bit         ok;
        ok = 1'b1;
        fails_before = uut.u_assert.fail_count;
        // Raster counters clear only on reset
        apply_reset();
        next_row_pulses = 0;
        job_start = 1'b1;
        wait_cycle();
        job_start = 1'b0;
        while (!job_complete) begin
            wait_cycle();
        end
        delay = next_random(MAX_DELAY);
        repeat (delay) wait_cycle();
        job_complete_ack = 1'b1;
        wait_cycle();
        job_complete_ack = 1'b0;
        repeat (DRAIN_CYCLES) wait_cycle();
        // Pointer steps once per next_row over four buffers
        expected_gray = gray_for_count(next_row_pulses);
        if (gray_code !== expected_gray) begin
            $display("CHECK FAILED gray_code expected %h got %h", expected_gray, gray_code);
            ok = 1'b0;
        end
        if (uut.u_assert.fail_count != fails_before) begin
            $display("job %0d hit %0d assertion failures", idx,
                     uut.u_assert.fail_count - fails_before);
            ok = 1'b0;
        end
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test job_%0d %s, %0d next_row pulses", idx, ok ? "ok" : "failed",
                 next_row_pulses);
    endtask

    //////////////////////////////////////////////////
    // Fetch responder
    //////////////////////////////////////////////////

    initial begin : fetch_responder
        int delay;
        forever begin
            wait_cycle();
            if (job_fetch_request) begin
                delay = next_random(MAX_DELAY);
                repeat (delay) wait_cycle();
                job_fetch_ack = 1'b1;
                wait_cycle();
                job_fetch_ack = 1'b0;
                // Row transfer time
                delay = next_random(MAX_DELAY);
                repeat (delay) wait_cycle();
                job_fetch_complete = 1'b1;
                wait_cycle();
                job_fetch_complete = 1'b0;
            end
        end
    end

    // Rows consumed only while the sequencer reads
    initial begin : row_stimulus
        int gap;
        gap = 0;
        forever begin
            wait_cycle();
            next_row = 1'b0;
            if (rst) begin
                gap = 0;
            end else if (seq_rden) begin
                if (gap == 0) begin
                    next_row = 1'b1;
                    next_row_pulses++;
                    gap = next_random(MAX_DELAY);
                end else begin
                    gap--;
                end
            end
        end
    end

    // Kernel flags coincide about one cycle in eight
    initial begin : kernel_stimulus
        forever begin
            wait_cycle();
            row_matric  = (next_random(2) == 0);
            last_kernel = (next_random(4) == 0);
        end
    end

    initial begin : complete_counter
        logic prev;
        prev = 1'b0;
        forever begin
            wait_cycle();
            if (job_complete && !prev) begin
                complete_pulses++;
            end
            prev = job_complete;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, jobs did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin : main_sequence
        clk                = 1'b0;
        rst                = 1'b1;
        lcg_state          = 32'hb853;
        num_input_cols     = coord_t'(COLS);
        num_input_rows     = coord_t'(ROWS);
        pfb_full_count     = pfb_count_t'(FULL_COUNT);
        job_start          = 1'b0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        row_matric         = 1'b0;
        last_kernel        = 1'b0;
        next_row           = 1'b0;
        next_row_pulses    = 0;
        complete_pulses    = 0;
        tests_run          = 0;
        tests_failed       = 0;
        for (int j = 0; j < JOBS; j++) begin
            run_job(j);
        end
        tests_run++;
        if (complete_pulses != JOBS) begin
            $display("CHECK FAILED complete_pulses expected %h got %h", JOBS, complete_pulses);
            tests_failed++;
        end
        $display("test completion_count %s", complete_pulses == JOBS ? "ok" : "failed");
        $display("tests run %0d, failed %0d, assertion failures %0d", tests_run,
                 tests_failed, uut.u_assert.fail_count);
        if (tests_failed == 0 && uut.u_assert.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
